/* Bender.yml */
package:
  name: cpu

sources:
  - logic/cpu_pkg.sv
  - logic/dp_ctrl_if.sv
  - logic/instr_decoder.sv
  - logic/controller_fsm.sv
  - logic/register_file.sv
  - logic/datapath.sv
  - logic/fetch_unit.sv
  - logic/cpu.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/cpu_tb.sv

/* cpu.f */
logic/cpu_pkg.sv
logic/dp_ctrl_if.sv
logic/instr_decoder.sv
logic/controller_fsm.sv
logic/register_file.sv
logic/datapath.sv
logic/fetch_unit.sv
logic/cpu.sv
+incdir+test
test/cpu_tb.sv

/* logic/controller_fsm.sv */
// multi-cycle fetch/execute state machine driving datapath and fetch controls
`timescale 1ns/1ps

module controller_fsm
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [2:0] opcode,
	input logic [1:0] op,
	input logic [2:0] cond,
	dp_ctrl_if.ctrl ctrl,
	output logic load_ir,
	output logic load_pc,
	output logic reset_pc,
	output logic branch_load,
	output logic addr_sel,
	output logic load_addr,
	output logic [1:0] mem_cmd,
	output logic halt
);

	logic [state_w-1:0] state;
	logic [state_w-1:0] next_state;
	logic [state_w-1:0] decoded; // first execute step of the fetched instruction
	logic taken;

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_reset;
		else
			state <= next_state;
	end

	always_comb begin
		case (opcode)
			opc_mov: decoded = op[1] ? st_mov_imm : st_mov_1; // op 10 carries imm8
			opc_alu: begin
				case (op)
					alu_cmp: decoded = st_cmp_1;
					alu_mvn: decoded = st_mov_1; // same steps as mov shifted
					default: decoded = st_alu_1;
				endcase
			end
			opc_ldr: decoded = st_ldr_1;
			opc_str: decoded = st_str_1;
			opc_halt: decoded = st_halt;
			opc_branch: decoded = st_branch;
			default: decoded = st_if1; // unknown opcode runs as a no-op
		endcase
	end

	always_comb begin
		case (state)
			st_reset: next_state = st_if1;
			st_if1: next_state = st_if2;
			st_if2: next_state = st_update_pc;
			st_update_pc: next_state = decoded;
			st_mov_1, st_mov_2, st_alu_1, st_alu_2, st_alu_3, st_cmp_1, st_cmp_2,
			st_ldr_1, st_ldr_2, st_ldr_3, st_ldr_4,
			st_str_1, st_str_2, st_str_3, st_str_4, st_str_5:
				next_state = state + 1'b1; // next step, same instruction
			st_halt: next_state = st_halt; // only reset leaves
			default: next_state = st_if1; // last step of every instruction
		endcase
	end

	always_comb begin
		case (cond)
			cond_always: taken = 1'b1;
			cond_eq: taken = ctrl.z;
			cond_ne: taken = ~ctrl.z;
			cond_lt: taken = ctrl.n ^ ctrl.v;
			cond_le: taken = (ctrl.n ^ ctrl.v) | ctrl.z;
			default: taken = 1'b0;
		endcase
	end

	// imm5 sits in the shift field for memory ops
	assign ctrl.shift_off = (state[7:4] == st_ldr_1[7:4]) || (state[7:4] == st_str_1[7:4]);
	assign halt = (state == st_halt);

	always_comb begin
		ctrl.nsel = nsel_rn;
		ctrl.vsel = vsel_c;
		ctrl.write = 1'b0;
		ctrl.loada = 1'b0;
		ctrl.loadb = 1'b0;
		ctrl.loadc = 1'b0;
		ctrl.loads = 1'b0;
		ctrl.asel = 1'b0;
		ctrl.bsel = 1'b0;
		load_ir = 1'b0;
		load_pc = 1'b0;
		reset_pc = 1'b0;
		branch_load = 1'b0;
		addr_sel = 1'b0;
		load_addr = 1'b0;
		mem_cmd = mem_none;
		case (state)
			st_reset: begin
				reset_pc = 1'b1;
				load_pc = 1'b1;
			end
			st_if1: begin
				addr_sel = 1'b1;
				mem_cmd = mem_read;
			end
			st_if2: begin
				addr_sel = 1'b1;
				mem_cmd = mem_read;
				load_ir = 1'b1;
			end
			st_update_pc: load_pc = 1'b1; // pc + 1
			st_mov_imm: begin
				ctrl.vsel = vsel_imm; // rn <= sximm8
				ctrl.write = 1'b1;
			end
			st_mov_1, st_mov_2: begin
				ctrl.nsel = nsel_rm;
				ctrl.asel = 1'b1; // c <= 0 op shifted rm
				ctrl.loadb = 1'b1;
				ctrl.loadc = 1'b1;
			end
			st_alu_1, st_cmp_1, st_ldr_1, st_str_1: ctrl.loada = 1'b1; // a <= rn
			st_alu_2, st_alu_3: begin
				ctrl.nsel = nsel_rm;
				ctrl.loadb = 1'b1;
				ctrl.loadc = 1'b1;
			end
			st_mov_3, st_alu_4: begin
				ctrl.nsel = nsel_rd;
				ctrl.write = 1'b1;
			end
			st_cmp_2: begin
				ctrl.nsel = nsel_rm; // b <= rm
				ctrl.loadb = 1'b1;
			end
			st_cmp_3: begin
				ctrl.nsel = nsel_rm;
				ctrl.loads = 1'b1; // flags from a - shifted b
			end
			st_ldr_2, st_str_2: begin
				ctrl.bsel = 1'b1; // c <= rn + sximm5
				ctrl.loadc = 1'b1;
			end
			st_ldr_3: begin
				load_addr = 1'b1;
				mem_cmd = mem_read;
			end
			st_ldr_4: mem_cmd = mem_read;
			st_ldr_5: begin
				mem_cmd = mem_read;
				ctrl.nsel = nsel_rd;
				ctrl.vsel = vsel_mem;
				ctrl.write = 1'b1;
			end
			st_str_3: begin
				load_addr = 1'b1;
				mem_cmd = mem_read;
				ctrl.nsel = nsel_rd; // b <= rd
				ctrl.loadb = 1'b1;
			end
			st_str_4: begin
				mem_cmd = mem_read;
				ctrl.asel = 1'b1; // c <= rd, the store value
				ctrl.loadc = 1'b1;
			end
			st_str_5: mem_cmd = mem_read;
			st_str_6: mem_cmd = mem_write;
			st_branch: begin
				branch_load = taken;
				load_pc = taken;
			end
			st_halt: begin
				reset_pc = 1'b1;
				load_pc = 1'b1;
				addr_sel = 1'b1;
			end
			default: ;
		endcase
	end

	a_mem_cmd_legal: assert property (@(posedge clk) disable iff (reset) mem_cmd != 2'b11)
		else $error("mem_cmd took the unused code");

	// register write and memory write never share a cycle
	a_no_dual_write: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.write && mem_cmd == mem_write))
		else $error("register write during memory write");

endmodule

/* logic/cpu.sv */
// processor top level connecting fetch, decode, control and datapath to memory
`timescale 1ns/1ps

module cpu
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [word_w-1:0] read_data,
	output logic [1:0] mem_cmd,
	output logic [addr_w-1:0] mem_addr,
	output logic [word_w-1:0] datapath_out,
	output logic halt
);

	dp_ctrl_if ctl_if ();

	instr_u instr;
	logic [2:0] opcode, cond;
	logic [1:0] op, shift;
	logic [word_w-1:0] sximm5, sximm8;
	logic [reg_w-1:0] regnum;
	logic [addr_w-1:0] pc;
	logic load_ir, load_pc, reset_pc, branch_load, addr_sel, load_addr;

	fetch_unit fetch_i (
		.clk(clk),
		.read_data(read_data),
		.load_ir(load_ir),
		.load_pc(load_pc),
		.reset_pc(reset_pc),
		.branch_load(branch_load),
		.load_addr(load_addr),
		.addr_sel(addr_sel),
		.sximm8(sximm8),
		.data_addr(datapath_out[addr_w-1:0]), // c holds the computed address
		.instr(instr),
		.pc(pc),
		.mem_addr(mem_addr)
	);

	instr_decoder dec_i (
		.instr(instr),
		.dp(ctl_if.dec),
		.opcode(opcode),
		.op(op),
		.cond(cond),
		.shift(shift),
		.sximm5(sximm5),
		.sximm8(sximm8),
		.regnum(regnum)
	);

	controller_fsm fsm_i (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.op(op),
		.cond(cond),
		.ctrl(ctl_if.ctrl),
		.load_ir(load_ir),
		.load_pc(load_pc),
		.reset_pc(reset_pc),
		.branch_load(branch_load),
		.addr_sel(addr_sel),
		.load_addr(load_addr),
		.mem_cmd(mem_cmd),
		.halt(halt)
	);

	datapath dp_i (
		.clk(clk),
		.dp(ctl_if.dp),
		.regnum(regnum),
		.shift(shift),
		.sximm5(sximm5),
		.sximm8(sximm8),
		.read_data(read_data),
		.pc(pc),
		.alu_op(op),
		.datapath_out(datapath_out)
	);

endmodule

/* logic/cpu_pkg.sv */
// widths, opcodes, fsm state codes, memory commands and the instruction word union
package cpu_pkg;

	localparam int word_w = 16;
	localparam int addr_w = 9;
	localparam int reg_w = 3;
	localparam int state_w = 8; // upper nibble = instruction, lower nibble = step

	localparam logic [state_w-1:0] st_reset = 8'h00;
	localparam logic [state_w-1:0] st_if1 = 8'h01;
	localparam logic [state_w-1:0] st_if2 = 8'h02;
	localparam logic [state_w-1:0] st_update_pc = 8'h03;
	localparam logic [state_w-1:0] st_mov_imm = 8'h10;
	localparam logic [state_w-1:0] st_mov_1 = 8'h20; // shared by mov shifted and mvn
	localparam logic [state_w-1:0] st_mov_2 = 8'h21;
	localparam logic [state_w-1:0] st_mov_3 = 8'h22;
	localparam logic [state_w-1:0] st_alu_1 = 8'h30; // add and and
	localparam logic [state_w-1:0] st_alu_2 = 8'h31;
	localparam logic [state_w-1:0] st_alu_3 = 8'h32;
	localparam logic [state_w-1:0] st_alu_4 = 8'h33;
	localparam logic [state_w-1:0] st_cmp_1 = 8'h40;
	localparam logic [state_w-1:0] st_cmp_2 = 8'h41;
	localparam logic [state_w-1:0] st_cmp_3 = 8'h42;
	localparam logic [state_w-1:0] st_ldr_1 = 8'h50;
	localparam logic [state_w-1:0] st_ldr_2 = 8'h51;
	localparam logic [state_w-1:0] st_ldr_3 = 8'h52;
	localparam logic [state_w-1:0] st_ldr_4 = 8'h53;
	localparam logic [state_w-1:0] st_ldr_5 = 8'h54;
	localparam logic [state_w-1:0] st_str_1 = 8'h60;
	localparam logic [state_w-1:0] st_str_2 = 8'h61;
	localparam logic [state_w-1:0] st_str_3 = 8'h62;
	localparam logic [state_w-1:0] st_str_4 = 8'h63;
	localparam logic [state_w-1:0] st_str_5 = 8'h64;
	localparam logic [state_w-1:0] st_str_6 = 8'h65;
	localparam logic [state_w-1:0] st_halt = 8'h70;
	localparam logic [state_w-1:0] st_branch = 8'ha0;

	localparam logic [2:0] opc_mov = 3'b110;
	localparam logic [2:0] opc_alu = 3'b101;
	localparam logic [2:0] opc_ldr = 3'b011;
	localparam logic [2:0] opc_str = 3'b100;
	localparam logic [2:0] opc_halt = 3'b111;
	localparam logic [2:0] opc_branch = 3'b001;

	localparam logic [1:0] alu_add = 2'b00;
	localparam logic [1:0] alu_cmp = 2'b01; // subtract, flags only
	localparam logic [1:0] alu_and = 2'b10;
	localparam logic [1:0] alu_mvn = 2'b11;

	localparam logic [2:0] cond_always = 3'b000;
	localparam logic [2:0] cond_eq = 3'b001;
	localparam logic [2:0] cond_ne = 3'b010;
	localparam logic [2:0] cond_lt = 3'b011;
	localparam logic [2:0] cond_le = 3'b100;

	localparam logic [1:0] mem_none = 2'b00;
	localparam logic [1:0] mem_read = 2'b01;
	localparam logic [1:0] mem_write = 2'b10;

	localparam logic [2:0] nsel_rn = 3'b001;
	localparam logic [2:0] nsel_rd = 3'b010;
	localparam logic [2:0] nsel_rm = 3'b100;

	localparam logic [3:0] vsel_c = 4'b0001;
	localparam logic [3:0] vsel_pc = 4'b0010;
	localparam logic [3:0] vsel_imm = 4'b0100;
	localparam logic [3:0] vsel_mem = 4'b1000;

	typedef union packed {
		struct packed {
			logic [2:0] opcode;
			logic [1:0] op;
			logic [2:0] rn;
			logic [2:0] rd;
			logic [1:0] shift;
			logic [2:0] rm;
		} r; // register format
		struct packed {
			logic [2:0] opcode;
			logic [1:0] op;
			logic [2:0] rn; // also branch condition
			logic [7:0] imm8; // low five bits are imm5
		} i; // immediate format
	} instr_u;

endpackage

/* logic/datapath.sv */
// operand registers, shifter, alu, status flags and write-back select
`timescale 1ns/1ps

module datapath
	import cpu_pkg::*;
(
	input logic clk,
	dp_ctrl_if.dp dp,
	input logic [reg_w-1:0] regnum,
	input logic [1:0] shift,
	input logic [word_w-1:0] sximm5,
	input logic [word_w-1:0] sximm8,
	input logic [word_w-1:0] read_data,
	input logic [addr_w-1:0] pc,
	input logic [1:0] alu_op,
	output logic [word_w-1:0] datapath_out
);

	logic [word_w-1:0] a_q, b_q, c_q;
	logic [word_w-1:0] reg_out, wb_data;
	logic [word_w-1:0] b_shift, ain, bin, alu_out;
	logic [1:0] shift_eff;
	logic b_sign, ovf;

	register_file rf_i (
		.clk(clk),
		.write(dp.write),
		.regnum(regnum),
		.data_in(wb_data),
		.data_out(reg_out)
	);

	always_comb begin
		case (dp.vsel)
			vsel_c: wb_data = c_q;
			vsel_pc: wb_data = {{(word_w-addr_w){1'b0}}, pc};
			vsel_imm: wb_data = sximm8;
			vsel_mem: wb_data = read_data;
			default: wb_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (dp.loada)
			a_q <= reg_out;
		if (dp.loadb)
			b_q <= reg_out;
		if (dp.loadc)
			c_q <= alu_out;
	end

	assign shift_eff = dp.shift_off ? 2'b00 : shift;

	always_comb begin
		case (shift_eff)
			2'b00: b_shift = b_q;
			2'b01: b_shift = {b_q[word_w-2:0], 1'b0};
			2'b10: b_shift = {1'b0, b_q[word_w-1:1]};
			2'b11: b_shift = {b_q[word_w-1], b_q[word_w-1:1]}; // keeps sign
		endcase
	end

	assign ain = dp.asel ? '0 : a_q;
	assign bin = dp.bsel ? sximm5 : b_shift;

	always_comb begin
		case (alu_op)
			alu_add: alu_out = ain + bin;
			alu_cmp: alu_out = ain - bin;
			alu_and: alu_out = ain & bin;
			alu_mvn: alu_out = ~bin;
		endcase
	end

	// signed overflow, subtract flips the sign of b
	assign b_sign = (alu_op == alu_cmp) ? ~bin[word_w-1] : bin[word_w-1];
	assign ovf = (alu_op == alu_add || alu_op == alu_cmp) &&
		(ain[word_w-1] == b_sign) && (alu_out[word_w-1] != ain[word_w-1]);

	always_ff @(posedge clk) begin
		if (dp.loads) begin
			dp.z <= (alu_out == '0);
			dp.n <= alu_out[word_w-1];
			dp.v <= ovf;
		end
	end

	assign datapath_out = c_q;

	a_v_known: assert property (@(posedge clk) dp.loads |=> !$isunknown(dp.v))
		else $error("overflow flag unknown after status load");

endmodule

/* logic/dp_ctrl_if.sv */
// controller to datapath command bus with status flags returned
`timescale 1ns/1ps

interface dp_ctrl_if;

	logic [2:0] nsel; // one-hot rn / rd / rm
	logic [3:0] vsel; // one-hot write-back source
	logic write;
	logic loada;
	logic loadb;
	logic loadc;
	logic loads;
	logic asel; // zero in place of a
	logic bsel; // sximm5 in place of shifted b
	logic shift_off;
	logic z;
	logic n;
	logic v;

	modport ctrl (
		output nsel, vsel, write, loada, loadb, loadc, loads, asel, bsel, shift_off,
		input z, n, v
	);

	modport dp (
		input nsel, vsel, write, loada, loadb, loadc, loads, asel, bsel, shift_off,
		output z, n, v
	);

	modport dec (
		input nsel
	);

endinterface

/* logic/fetch_unit.sv */
// program counter, instruction register, data address register and address mux
`timescale 1ns/1ps

module fetch_unit
	import cpu_pkg::*;
(
	input logic clk,
	input logic [word_w-1:0] read_data,
	input logic load_ir,
	input logic load_pc,
	input logic reset_pc,
	input logic branch_load,
	input logic load_addr,
	input logic addr_sel,
	input logic [word_w-1:0] sximm8,
	input logic [addr_w-1:0] data_addr,
	output instr_u instr,
	output logic [addr_w-1:0] pc,
	output logic [addr_w-1:0] mem_addr
);

	logic [addr_w-1:0] next_pc;
	logic [addr_w-1:0] data_addr_q;

	always_comb begin
		if (reset_pc)
			next_pc = '0;
		else if (branch_load)
			next_pc = pc + sximm8[addr_w-1:0]; // pc already points past the branch
		else
			next_pc = pc + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (load_ir)
			instr <= read_data;
		if (load_pc)
			pc <= next_pc;
		if (load_addr)
			data_addr_q <= data_addr;
	end

	// bus parks at zero while the pc is being cleared
	assign mem_addr = reset_pc ? '0 : (addr_sel ? pc : data_addr_q);

	a_ir_addr_excl: assert property (@(posedge clk) !(load_ir && load_addr))
		else $error("instruction and data address loaded together");

endmodule

/* logic/instr_decoder.sv */
// instruction field split, immediate sign extension and register number select
`timescale 1ns/1ps

module instr_decoder
	import cpu_pkg::*;
(
	input instr_u instr,
	dp_ctrl_if.dec dp,
	output logic [2:0] opcode,
	output logic [1:0] op,
	output logic [2:0] cond,
	output logic [1:0] shift,
	output logic [word_w-1:0] sximm5,
	output logic [word_w-1:0] sximm8,
	output logic [reg_w-1:0] regnum
);

	assign opcode = instr.r.opcode;
	assign op = instr.r.op; // also drives the alu op
	assign cond = instr.i.rn; // branches reuse the rn slot
	assign shift = instr.r.shift;

	assign sximm8 = {{(word_w-8){instr.i.imm8[7]}}, instr.i.imm8};
	assign sximm5 = {{(word_w-5){instr.i.imm8[4]}}, instr.i.imm8[4:0]};

	// one register number serves both read and write
	always_comb begin
		case (dp.nsel)
			nsel_rn: regnum = instr.r.rn;
			nsel_rd: regnum = instr.r.rd;
			nsel_rm: regnum = instr.r.rm;
			default: regnum = '0;
		endcase
	end

endmodule

/* logic/register_file.sv */
// eight-entry register file, one shared read/write port
`timescale 1ns/1ps

module register_file
	import cpu_pkg::*;
(
	input logic clk,
	input logic write,
	input logic [reg_w-1:0] regnum,
	input logic [word_w-1:0] data_in,
	output logic [word_w-1:0] data_out
);

	logic [word_w-1:0] regs [0:(1<<reg_w)-1];

	always_ff @(posedge clk) begin
		if (write)
			regs[regnum] <= data_in;
	end

	assign data_out = regs[regnum]; // combinational read

endmodule

/* test/cpu_ref.svh */
// instruction encoders, program emitter and instruction-set reference model
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

function automatic logic [15:0] enc_reg(logic [2:0] opc, logic [1:0] op, logic [2:0] rn,
		logic [2:0] rd, logic [1:0] sh, logic [2:0] rm);
	return {opc, op, rn, rd, sh, rm};
endfunction

function automatic logic [15:0] enc_imm(logic [2:0] opc, logic [1:0] op, logic [2:0] rn,
		logic [7:0] imm8);
	return {opc, op, rn, imm8};
endfunction

// load/store keep rd in bits 7:5 and the offset in bits 4:0
function automatic logic [15:0] enc_mem(logic [2:0] opc, logic [2:0] rd, logic [2:0] rn,
		logic [4:0] imm5);
	return {opc, 2'b00, rn, rd, imm5};
endfunction

task automatic emit(input logic [15:0] word);
	image[prog_len] = word;
	prog_len++;
endtask

function automatic logic [15:0] shift_op(logic [15:0] x, logic [1:0] sh);
	case (sh)
		2'd1: return x << 1;
		2'd2: return x >> 1; // logical
		2'd3: return $signed(x) >>> 1;
		default: return x;
	endcase
endfunction

function automatic logic cond_taken(logic [2:0] c, logic eq_f, logic lt_f);
	case (c)
		cond_always: return 1'b1;
		cond_eq: return eq_f;
		cond_ne: return !eq_f;
		cond_lt: return lt_f; // signed compare of the last cmp
		cond_le: return lt_f || eq_f;
		default: return 1'b0;
	endcase
endfunction

// runs ref_mem from address zero up to halt and collects the expected stores
function automatic int run_reference();
	instr_u ir;
	logic [15:0] r [8];
	logic [15:0] b;
	logic [8:0] pc;
	logic [8:0] ea;
	logic eq_f;
	logic lt_f;
	int steps;
	pc = '0;
	steps = 0;
	eq_f = 1'b0;
	lt_f = 1'b0;
	exp_addr.delete();
	exp_data.delete();
	foreach (r[k])
		r[k] = '0;
	while (steps < 4096) begin
		ir = ref_mem[pc];
		pc = pc + 1'b1; // branches count from the next word
		steps++;
		b = shift_op(r[ir.r.rm], ir.r.shift);
		ea = r[ir.r.rn][8:0] + {{4{ir.i.imm8[4]}}, ir.i.imm8[4:0]};
		case (ir.r.opcode)
			opc_mov: begin
				if (ir.r.op[1])
					r[ir.i.rn] = {{8{ir.i.imm8[7]}}, ir.i.imm8};
				else
					r[ir.r.rd] = b;
			end
			opc_alu: begin
				case (ir.r.op)
					alu_add: r[ir.r.rd] = r[ir.r.rn] + b;
					alu_and: r[ir.r.rd] = r[ir.r.rn] & b;
					alu_mvn: r[ir.r.rd] = ~b;
					default: begin
						eq_f = (r[ir.r.rn] == b);
						lt_f = ($signed(r[ir.r.rn]) < $signed(b));
					end
				endcase
			end
			opc_ldr: r[ir.r.rd] = ref_mem[ea];
			opc_str: begin
				ref_mem[ea] = r[ir.r.rd];
				exp_addr.push_back(ea);
				exp_data.push_back(r[ir.r.rd]);
			end
			opc_branch: begin
				if (cond_taken(ir.i.rn, eq_f, lt_f))
					pc = pc + {ir.i.imm8[7], ir.i.imm8};
			end
			opc_halt: begin
				ref_halt_pc = pc - 1'b1;
				return steps;
			end
			default: ; // unused opcodes do nothing
		endcase
	end
	return steps;
endfunction

`endif

/* test/cpu_tb.sv */
// testbench for the cpu with clock, reset, memory model, test programs and store checks
`timescale 1ns/1ps

module cpu_tb
	import cpu_pkg::*;
();

	logic clk;
	logic reset;
	logic [word_w-1:0] read_data;
	logic [1:0] mem_cmd;
	logic [addr_w-1:0] mem_addr;
	logic [word_w-1:0] datapath_out;
	logic halt;

	logic [word_w-1:0] mem [0:511];
	logic [word_w-1:0] image [0:511]; // program and data image of the next test
	logic [word_w-1:0] ref_mem [0:511];
	logic [addr_w-1:0] exp_addr [$];
	logic [word_w-1:0] exp_data [$];
	logic [addr_w-1:0] ref_halt_pc;
	logic [addr_w-1:0] last_read;
	int prog_len;
	int wr_idx;
	int value_errors;
	int other_errors;
	int cycles;
	int cycle_limit = 8;
	string test_name;

	`include "cpu_ref.svh"

	cpu dut_i (
		.clk(clk),
		.reset(reset),
		.read_data(read_data),
		.mem_cmd(mem_cmd),
		.mem_addr(mem_addr),
		.datapath_out(datapath_out),
		.halt(halt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	assign read_data = mem[mem_addr]; // same-cycle read

	// memory write port and in-order store check
	always @(posedge clk) begin
		if (mem_cmd == mem_write) begin
			mem[mem_addr] <= datapath_out;
			assert (wr_idx < exp_addr.size()) else begin
				other_errors++;
				$display("%s: unexpected memory write to address %h", test_name, mem_addr);
			end
			if (wr_idx < exp_addr.size()) begin
				assert (mem_addr == exp_addr[wr_idx]) else begin
					value_errors++;
					$display("[ERROR] %s: store %0d address expected %h, actual %h",
						test_name, wr_idx, exp_addr[wr_idx], mem_addr);
				end
				assert (datapath_out == exp_data[wr_idx]) else begin
					value_errors++;
					$display("[ERROR] %s: store %0d value expected %h, actual %h",
						test_name, wr_idx, exp_data[wr_idx], datapath_out);
				end
			end
			wr_idx++;
		end
		if (mem_cmd == mem_read)
			last_read <= mem_addr; // ends on the fetch of the halt word
	end

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT did not reach halt in time", cycles);
		$display("Finished with errors");
		$finish;
	end

	task automatic start_image();
		foreach (image[a])
			image[a] = {a[8:0], a[6:0]} ^ 16'h9c35;
		prog_len = 0;
	endtask

	task automatic build_alu_program();
		logic [7:0] x;
		logic [7:0] y;
		start_image();
		emit(enc_imm(opc_mov, 2'b10, 3'd7, 8'h70)); // store base
		for (int k = 0; k < 4; k++) begin
			x = $urandom;
			y = $urandom;
			emit(enc_imm(opc_mov, 2'b10, 3'd1, x));
			emit(enc_imm(opc_mov, 2'b10, 3'd2, y));
			emit(enc_reg(opc_alu, alu_add, 3'd1, 3'd3, 2'(k), 3'd2));
			emit(enc_mem(opc_str, 3'd3, 3'd7, 5'(4 * k)));
			emit(enc_reg(opc_alu, alu_and, 3'd1, 3'd4, 2'(k), 3'd2));
			emit(enc_mem(opc_str, 3'd4, 3'd7, 5'(4 * k + 1)));
			emit(enc_reg(opc_alu, alu_mvn, 3'd0, 3'd5, 2'(k), 3'd2));
			emit(enc_mem(opc_str, 3'd5, 3'd7, 5'(4 * k + 2)));
			emit(enc_reg(opc_mov, 2'b00, 3'd0, 3'd6, 2'(k), 3'd2));
			emit(enc_mem(opc_str, 3'd6, 3'd7, 5'(4 * k + 3)));
		end
		emit(enc_imm(opc_halt, 2'b00, 3'd0, 8'h00));
	endtask

	// each condition picks one of two markers, then both paths meet at the store
	task automatic build_branch_program();
		logic [7:0] x;
		logic [7:0] y;
		logic [2:0] conds [4] = '{cond_eq, cond_ne, cond_lt, cond_le};
		start_image();
		emit(enc_imm(opc_mov, 2'b10, 3'd7, 8'h70));
		for (int t = 0; t < 4; t++) begin
			x = $urandom;
			y = (t == 0) ? x : 8'($urandom); // first pair is equal
			emit(enc_imm(opc_mov, 2'b10, 3'd1, x));
			emit(enc_imm(opc_mov, 2'b10, 3'd2, y));
			emit(enc_reg(opc_alu, alu_cmp, 3'd1, 3'd0, 2'd0, 3'd2));
			for (int c = 0; c < 4; c++) begin
				emit(enc_imm(opc_branch, 2'b00, conds[c], 8'd2));
				emit(enc_imm(opc_mov, 2'b10, 3'd3, 8'(t * 16 + c * 2)));
				emit(enc_imm(opc_branch, 2'b00, cond_always, 8'd1));
				emit(enc_imm(opc_mov, 2'b10, 3'd3, 8'(t * 16 + c * 2 + 1)));
				emit(enc_mem(opc_str, 3'd3, 3'd7, 5'(t * 4 + c - 8)));
			end
		end
		emit(enc_imm(opc_halt, 2'b00, 3'd0, 8'h00));
	endtask

	task automatic build_copy_program();
		start_image();
		emit(enc_imm(opc_mov, 2'b10, 3'd6, 8'h80)); // source base wraps to 0x180
		emit(enc_imm(opc_mov, 2'b10, 3'd7, 8'h70));
		for (int j = 0; j < 8; j++) begin
			image[384 + j * 3 - 12] = $urandom;
			emit(enc_mem(opc_ldr, 3'(j % 6), 3'd6, 5'(j * 3 - 12)));
			emit(enc_mem(opc_str, 3'(j % 6), 3'd7, 5'(j - 4)));
		end
		emit(enc_imm(opc_halt, 2'b00, 3'd0, 8'h00));
	endtask

	task automatic run_test(input string name);
		int steps;
		test_name = name;
		foreach (ref_mem[a])
			ref_mem[a] = image[a];
		steps = run_reference();
		cycle_limit += 10 * steps + 40; // reset and halt watch on top
		foreach (mem[a])
			mem[a] = image[a];
		wr_idx = 0;
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		assert (mem_cmd == mem_none && halt == 1'b0) else begin
			other_errors++;
			$display("%s: memory command or halt active during reset", name);
		end
		reset <= 1'b0;
		@(posedge clk);
		assert (mem_cmd == mem_none && halt == 1'b0) else begin
			other_errors++;
			$display("%s: memory command or halt active right after reset", name);
		end
		do
			@(posedge clk);
		while (mem_cmd != mem_read);
		assert (mem_addr == '0) else begin
			value_errors++;
			$display("[ERROR] %s: first read address expected %h, actual %h", name, 9'h0, mem_addr);
		end
		while (!halt)
			@(posedge clk);
		assert (last_read == ref_halt_pc) else begin
			value_errors++;
			$display("[ERROR] %s: halt address expected %h, actual %h", name, ref_halt_pc, last_read);
		end
		repeat (16) begin
			@(posedge clk);
			assert (halt && mem_addr == '0 && mem_cmd != mem_write) else begin
				other_errors++;
				$display("%s: halt dropped or memory still active while halted", name);
			end
		end
		assert (wr_idx == exp_addr.size()) else begin
			value_errors++;
			$display("[ERROR] %s: store count expected %0d, actual %0d", name, exp_addr.size(), wr_idx);
		end
		foreach (mem[a]) begin
			assert (mem[a] === ref_mem[a]) else begin
				value_errors++;
				$display("[ERROR] %s: memory %h expected %h, actual %h", name, a[8:0], ref_mem[a], mem[a]);
			end
		end
	endtask

	initial begin
		void'($urandom(32'hc921_1b5b));
		reset = 1'b1;
		value_errors = 0;
		other_errors = 0;
		wr_idx = 0;
		prog_len = 0;
		test_name = "init";
		foreach (mem[a])
			mem[a] = '0;
		build_alu_program();
		run_test("mov_alu");
		build_branch_program();
		run_test("cmp_branch");
		build_copy_program();
		run_test("load_store");
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
